// File: logic/rvPkg.sv
package rvPkg;

    localparam int XLEN       = 32;
    localparam int REG_COUNT  = 32;
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);   // word index taken from addr bits above 1:0

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcodeT;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_XOR = 3'b100,
        ALU_SLL = 3'b101
    } aluOpT;

    typedef enum logic [1:0] {
        RES_ALU  = 2'b00,
        RES_MEM  = 2'b01,
        RES_LINK = 2'b10
    } resultSrcT;

    // kind of pc change; taken or not is settled in execute
    typedef enum logic [2:0] {
        PC_PLUS4     = 3'b000,
        PC_BRANCH_EQ = 3'b001,
        PC_BRANCH_NE = 3'b010,
        PC_JAL       = 3'b011,
        PC_JALR      = 3'b100
    } pcSrcT;

    typedef struct packed {
        logic      regWrite;
        logic      memWrite;
        resultSrcT resultSrc;
        aluOpT     aluOp;
        logic      aluSrcImm;   // second operand is imm
        pcSrcT     pcSrc;
    } ctrlSignals;

    typedef struct packed {
        ctrlSignals        ctrl;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        logic [4:0]        rd;
        logic [XLEN-1:0]   imm;
    } decodedInstr;

    typedef struct packed {
        logic [XLEN-1:0] aluResult;
        logic [XLEN-1:0] storeData;
        logic [XLEN-1:0] linkPc;    // pc + 4
        logic [XLEN-1:0] nextPc;
    } execResult;

endpackage

// File: logic/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  logic [rvPkg::XLEN-1:0] instr,
    output rvPkg::decodedInstr     dec
);
    import rvPkg::*;

    opcodeT          opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] immI;
    logic [XLEN-1:0] immS;
    logic [XLEN-1:0] immB;
    logic [XLEN-1:0] immJ;

    assign opcode = opcodeT'(instr[6:0]);
    assign funct3 = instr[14:12];

    // sign-extended immediates for each format
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign dec.rs1 = instr[19:15];
    assign dec.rs2 = instr[24:20];
    assign dec.rd  = instr[11:7];

    always_comb begin
        // no-op by default, pc just moves on
        dec.ctrl.regWrite  = 1'b0;
        dec.ctrl.memWrite  = 1'b0;
        dec.ctrl.resultSrc = RES_ALU;
        dec.ctrl.aluOp     = ALU_ADD;
        dec.ctrl.aluSrcImm = 1'b0;
        dec.ctrl.pcSrc     = PC_PLUS4;
        dec.imm            = immI;

        case (opcode)
            OP: begin
                dec.ctrl.regWrite = 1'b1;
                case (funct3)
                    3'b000: dec.ctrl.aluOp = instr[30] ? ALU_SUB : ALU_ADD;
                    3'b001: dec.ctrl.aluOp = ALU_SLL;
                    3'b100: dec.ctrl.aluOp = ALU_XOR;
                    3'b110: dec.ctrl.aluOp = ALU_OR;
                    3'b111: dec.ctrl.aluOp = ALU_AND;
                    default: dec.ctrl.regWrite = 1'b0;
                endcase
            end
            OP_IMM: begin
                dec.ctrl.regWrite  = 1'b1;
                dec.ctrl.aluSrcImm = 1'b1;
                case (funct3)
                    3'b000: dec.ctrl.aluOp = ALU_ADD;   // addi
                    3'b001: dec.ctrl.aluOp = ALU_SLL;   // slli, shamt in imm[4:0]
                    3'b100: dec.ctrl.aluOp = ALU_XOR;
                    3'b110: dec.ctrl.aluOp = ALU_OR;
                    3'b111: dec.ctrl.aluOp = ALU_AND;
                    default: dec.ctrl.regWrite = 1'b0;
                endcase
            end
            LOAD: begin
                if (funct3 == 3'b010) begin             // lw only
                    dec.ctrl.regWrite  = 1'b1;
                    dec.ctrl.resultSrc = RES_MEM;
                    dec.ctrl.aluSrcImm = 1'b1;
                end
            end
            STORE: begin
                dec.imm = immS;
                if (funct3 == 3'b010) begin             // sw only
                    dec.ctrl.memWrite  = 1'b1;
                    dec.ctrl.aluSrcImm = 1'b1;
                end
            end
            BRANCH: begin
                dec.imm = immB;
                if (funct3 == 3'b000)
                    dec.ctrl.pcSrc = PC_BRANCH_EQ;
                else if (funct3 == 3'b001)
                    dec.ctrl.pcSrc = PC_BRANCH_NE;
            end
            JAL: begin
                dec.imm            = immJ;
                dec.ctrl.regWrite  = 1'b1;
                dec.ctrl.resultSrc = RES_LINK;
                dec.ctrl.pcSrc     = PC_JAL;
            end
            JALR: begin
                if (funct3 == 3'b000) begin
                    dec.ctrl.regWrite  = 1'b1;
                    dec.ctrl.resultSrc = RES_LINK;
                    dec.ctrl.aluSrcImm = 1'b1;      // target is rs1 + imm
                    dec.ctrl.pcSrc     = PC_JALR;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: logic/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [4:0]             rs1,
    input  logic [4:0]             rs2,
    output logic [rvPkg::XLEN-1:0] rs1Data,
    output logic [rvPkg::XLEN-1:0] rs2Data,
    input  logic                   writeEn,
    input  logic [4:0]             writeAddr,
    input  logic [rvPkg::XLEN-1:0] writeData
);
    import rvPkg::*;

    logic [XLEN-1:0] regs [REG_COUNT];

    assign rs1Data = regs[rs1];
    assign rs2Data = regs[rs2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++)
                regs[i] <= '0;
        end else if (writeEn && writeAddr != 5'd0) begin   // x0 stays zero
            regs[writeAddr] <= writeData;
        end
    end

endmodule

// File: logic/aluExecute.sv
`timescale 1ns/1ps

module aluExecute (
    input  rvPkg::decodedInstr     dec,
    input  logic [rvPkg::XLEN-1:0] rs1Data,
    input  logic [rvPkg::XLEN-1:0] rs2Data,
    input  logic [rvPkg::XLEN-1:0] pc,
    output rvPkg::execResult       exec
);
    import rvPkg::*;

    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] aluOut;
    logic [XLEN-1:0] diff;
    logic            zero;
    logic [XLEN-1:0] pcPlus4;
    logic [XLEN-1:0] pcTarget;

    assign opB = dec.ctrl.aluSrcImm ? dec.imm : rs2Data;

    // branch compare always on the two registers
    assign diff = rs1Data - rs2Data;
    assign zero = (diff == '0);

    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + dec.imm;     // branch and jal target

    always_comb begin
        case (dec.ctrl.aluOp)
            ALU_ADD: aluOut = rs1Data + opB;
            ALU_SUB: aluOut = rs1Data - opB;
            ALU_AND: aluOut = rs1Data & opB;
            ALU_OR:  aluOut = rs1Data | opB;
            ALU_XOR: aluOut = rs1Data ^ opB;
            ALU_SLL: aluOut = rs1Data << opB[4:0];
            default: aluOut = '0;
        endcase
    end

    always_comb begin
        case (dec.ctrl.pcSrc)
            PC_BRANCH_EQ: exec.nextPc = zero ? pcTarget : pcPlus4;
            PC_BRANCH_NE: exec.nextPc = zero ? pcPlus4 : pcTarget;
            PC_JAL:       exec.nextPc = pcTarget;
            PC_JALR:      exec.nextPc = {aluOut[XLEN-1:1], 1'b0};  // bit 0 cleared
            default:      exec.nextPc = pcPlus4;
        endcase
    end

    assign exec.aluResult = aluOut;
    assign exec.linkPc    = pcPlus4;
    assign exec.storeData = rs2Data;

endmodule

// File: logic/resultStage.sv
`timescale 1ns/1ps

module resultStage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   instrValid,
    input  rvPkg::ctrlSignals      ctrl,
    input  logic [4:0]             rd,
    input  rvPkg::execResult       exec,
    output logic                   regWriteEn,
    output logic [4:0]             regWriteAddr,
    output logic [rvPkg::XLEN-1:0] regWriteData,
    output logic [rvPkg::XLEN-1:0] pc,
    output logic                   wbValid,
    output logic [4:0]             wbReg,
    output logic [rvPkg::XLEN-1:0] wbData
);
    import rvPkg::*;

    logic [XLEN-1:0]       dmem [DMEM_WORDS];
    logic [DMEM_IDX_W-1:0] memIdx;
    logic [XLEN-1:0]       memRdata;
    logic [XLEN-1:0]       result;

    // higher address bits ignored
    assign memIdx   = exec.aluResult[DMEM_IDX_W+1:2];
    assign memRdata = dmem[memIdx];

    always_comb begin
        case (ctrl.resultSrc)
            RES_MEM:  result = memRdata;
            RES_LINK: result = exec.linkPc;
            default:  result = exec.aluResult;
        endcase
    end

    // regfile writes on the same edge as everything else
    assign regWriteEn   = instrValid & ctrl.regWrite;
    assign regWriteAddr = rd;
    assign regWriteData = result;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DMEM_WORDS; i++)
                dmem[i] <= '0;
        end else if (instrValid && ctrl.memWrite) begin
            dmem[memIdx] <= exec.storeData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= '0;
            wbValid <= 1'b0;
        end else begin
            wbValid <= instrValid & ctrl.regWrite;  // x0 writes reported too
            if (instrValid)
                pc <= exec.nextPc;
        end
    end

    // report payload, only meaningful with wbValid
    always_ff @(posedge clk) begin
        if (instrValid && ctrl.regWrite) begin
            wbReg  <= rd;
            wbData <= result;
        end
    end

endmodule

// File: logic/rvCore.sv
`timescale 1ns/1ps

module rvCore (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   instrValid,
    input  logic [rvPkg::XLEN-1:0] instr,
    output logic [rvPkg::XLEN-1:0] pc,
    output logic                   wbValid,
    output logic [4:0]             wbReg,
    output logic [rvPkg::XLEN-1:0] wbData
);
    import rvPkg::*;

    decodedInstr     dec;
    execResult       exec;
    logic [XLEN-1:0] rs1Data;
    logic [XLEN-1:0] rs2Data;
    logic            regWriteEn;
    logic [4:0]      regWriteAddr;
    logic [XLEN-1:0] regWriteData;

    instrDecoder u_instrDecoder (
        .instr (instr),
        .dec   (dec)
    );

    regFile u_regFile (
        .clk       (clk),
        .reset     (reset),
        .rs1       (dec.rs1),
        .rs2       (dec.rs2),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .writeEn   (regWriteEn),
        .writeAddr (regWriteAddr),
        .writeData (regWriteData)
    );

    aluExecute u_aluExecute (
        .dec     (dec),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .pc      (pc),
        .exec    (exec)
    );

    resultStage u_resultStage (
        .clk          (clk),
        .reset        (reset),
        .instrValid   (instrValid),
        .ctrl         (dec.ctrl),
        .rd           (dec.rd),
        .exec         (exec),
        .regWriteEn   (regWriteEn),
        .regWriteAddr (regWriteAddr),
        .regWriteData (regWriteData),
        .pc           (pc),
        .wbValid      (wbValid),
        .wbReg        (wbReg),
        .wbData       (wbData)
    );

endmodule

// File: bench/rvCoreTb.sv
`timescale 1ns/1ps

module rvCoreTb;
    import rvPkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 2;
    localparam int NUM_CYCLES   = 3000;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_CYCLES + 20) * CLK_PERIOD;

    typedef struct packed {
        logic            wbValid;
        logic [4:0]      wbReg;
        logic [XLEN-1:0] wbData;
        logic [XLEN-1:0] pc;
    } expectT;

    logic            clk;
    logic            reset;
    logic            instrValid;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] pc;
    logic            wbValid;
    logic [4:0]      wbReg;
    logic [XLEN-1:0] wbData;

    integer          seed = 32'h8134ac74;
    int              errors = 0;
    int              checks = 0;
    expectT          expQ[$];     // one entry per cycle, checked a cycle later
    logic [XLEN-1:0] modelRegs [REG_COUNT];
    logic [XLEN-1:0] modelMem [DMEM_WORDS];
    logic [XLEN-1:0] modelPc = '0;

    rvCore u_rvCore (
        .clk        (clk),
        .reset      (reset),
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .wbValid    (wbValid),
        .wbReg      (wbReg),
        .wbData     (wbData)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int randBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // supported instructions on x0..x7, plus an odd unsupported one
    function automatic logic [XLEN-1:0] genInstr();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [12:0] bOff;
        logic [20:0] jOff;
        logic [2:0]  f3;
        int          kind;
        rd   = 5'(randBelow(8));
        rs1  = 5'(randBelow(8));
        rs2  = 5'(randBelow(8));
        imm  = 12'($random(seed));
        bOff = 13'((randBelow(16) - 8) * 2);
        jOff = 21'((randBelow(32) - 16) * 2);
        kind = randBelow(20);
        case (randBelow(5))
            0: f3 = 3'b000;
            1: f3 = 3'b001;
            2: f3 = 3'b100;
            3: f3 = 3'b110;
            default: f3 = 3'b111;
        endcase
        if (kind < 6) begin
            // sub only shares funct3 with add
            return {1'b0, (f3 == 3'b000) ? randBelow(2) == 1 : 1'b0, 5'd0, rs2, rs1, f3, rd,
                    7'b0110011};
        end else if (kind < 11) begin
            if (f3 == 3'b001)
                imm = {7'd0, imm[4:0]};     // slli shamt
            return {imm, rs1, f3, rd, 7'b0010011};
        end else if (kind < 13) begin
            return {12'(randBelow(64) * 4), 5'd0, 3'b010, rd, 7'b0000011};
        end else if (kind < 15) begin
            imm = 12'(randBelow(64) * 4);
            return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
        end else if (kind < 17) begin
            return {bOff[12], bOff[10:5], rs2, rs1, 2'b00, randBelow(2) == 1, bOff[4:1],
                    bOff[11], 7'b1100011};
        end else if (kind == 17) begin
            return {jOff[20], jOff[10:1], jOff[11], jOff[19:12], rd, 7'b1101111};
        end else if (kind == 18) begin
            return {12'(randBelow(32) * 2), 5'd0, 3'b000, rd, 7'b1100111};
        end
        // lui and slt are not implemented
        if (randBelow(2) == 0)
            return {imm, rs1, 3'b000, rd, 7'b0110111};
        return {7'd0, rs2, rs1, 3'b010, rd, 7'b0110011};
    endfunction

    function automatic expectT refExecute(input logic [XLEN-1:0] ins);
        expectT          e;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] immI;
        logic [XLEN-1:0] immS;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] res;
        logic [XLEN-1:0] nextPc;
        logic [2:0]      f3;
        logic            wr;
        a      = modelRegs[ins[19:15]];
        b      = modelRegs[ins[24:20]];
        f3     = ins[14:12];
        immI   = {{20{ins[31]}}, ins[31:20]};
        immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        res    = '0;
        wr     = 1'b0;
        nextPc = modelPc + 32'd4;
        case (ins[6:0])
            7'b0110011, 7'b0010011: begin
                if (!ins[5])
                    b = immI;           // immediate form
                wr = (f3 != 3'b010 && f3 != 3'b011 && f3 != 3'b101);
                case (f3)
                    3'b000: res = (ins[5] && ins[30]) ? a - b : a + b;
                    3'b001: res = a << b[4:0];
                    3'b100: res = a ^ b;
                    3'b110: res = a | b;
                    default: res = a & b;
                endcase
            end
            7'b0000011: begin
                addr = a + immI;
                res  = modelMem[addr[7:2]];
                wr   = (f3 == 3'b010);
            end
            7'b0100011: begin
                addr = a + immS;
                if (f3 == 3'b010)
                    modelMem[addr[7:2]] = b;
            end
            7'b1100011: begin
                if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b))
                    nextPc = modelPc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                        ins[11:8], 1'b0};
            end
            7'b1101111: begin
                res    = modelPc + 32'd4;
                wr     = 1'b1;
                nextPc = modelPc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                    ins[30:21], 1'b0};
            end
            7'b1100111: begin
                if (f3 == 3'b000) begin
                    addr   = a + immI;
                    res    = modelPc + 32'd4;
                    wr     = 1'b1;
                    nextPc = {addr[XLEN-1:1], 1'b0};
                end
            end
            default: ;
        endcase
        if (wr && ins[11:7] != 5'd0)
            modelRegs[ins[11:7]] = res;
        modelPc   = nextPc;
        e.wbValid = wr;
        e.wbReg   = ins[11:7];
        e.wbData  = res;
        e.pc      = nextPc;
        return e;
    endfunction

    task automatic checkOutputs(input expectT e);
        checks++;
        assert (pc == e.pc) else begin
            errors++;
            $display("ERROR at %0t: pc expected %h, actual %h", $time, e.pc, pc);
        end
        assert (wbValid == e.wbValid) else begin
            errors++;
            $display("ERROR at %0t: wbValid expected %b, actual %b", $time, e.wbValid, wbValid);
        end
        if (e.wbValid) begin
            assert (wbReg == e.wbReg) else begin
                errors++;
                $display("ERROR at %0t: wbReg expected %0d, actual %0d", $time, e.wbReg, wbReg);
            end
            assert (wbData == e.wbData) else begin
                errors++;
                $display("ERROR at %0t: wbData expected %h, actual %h", $time, e.wbData, wbData);
            end
        end
    endtask

    task automatic driveCycle(input logic valid);
        logic [XLEN-1:0] ins;
        expectT          e;
        ins = genInstr();
        instrValid <= valid;
        instr      <= ins;      // garbage when idle, must be ignored
        if (valid) begin
            e = refExecute(ins);
        end else begin
            e = '0;
            e.pc = modelPc;
        end
        expQ.push_back(e);
    endtask

    initial begin
        expectT e;
        reset      <= 1'b1;
        instrValid <= 1'b0;
        instr      <= '0;
        for (int i = 0; i < REG_COUNT; i++)
            modelRegs[i] = '0;
        for (int i = 0; i < DMEM_WORDS; i++)
            modelMem[i] = '0;
        @(posedge clk);
        e = '0;
        expQ.push_back(e);      // state right after reset
        repeat (RESET_CYCLES - 1) @(posedge clk);
        reset <= 1'b0;
        for (int n = 0; n < NUM_CYCLES; n++) begin
            driveCycle(randBelow(10) < 8);
            @(posedge clk);
        end
        repeat (3) begin
            driveCycle(1'b0);
            @(posedge clk);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    // compare once outputs have settled
    initial begin
        forever begin
            @(negedge clk);
            if (expQ.size() >= 2)
                checkOutputs(expQ.pop_front());
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the test did not finish", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: flist.f
logic/rvPkg.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/aluExecute.sv
logic/resultStage.sv
logic/rvCore.sv
bench/rvCoreTb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and pass only if the pass message shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module rvCoreTb -o rvCoreSim &&
out="$(./obj_dir/rvCoreSim)" &&
printf '%s\n' "$out" &&
printf '%s\n' "$out" | grep -qx "Finished with no errors" ||
exit 1
